/* hdl/memBridge_params.svh */
`ifndef MEMBRIDGE_PARAMS_SVH
`define MEMBRIDGE_PARAMS_SVH

// byte address into the RAM
`define MB_ADDR_W 32

// instruction and data word
`define MB_WORD_W 32

// bytes per instruction fetch
`define MB_FETCH_LEN 4

`endif

/* hdl/memBridgePkg.sv */
`default_nettype none
`include "memBridge_params.svh"

package memBridgePkg;

    // access length as a byte count, only 1, 2 and 4 are legal
    typedef logic [2:0] accLen_t;

    localparam accLen_t LenByte = 3'd1;
    localparam accLen_t LenHalf = 3'd2;
    localparam accLen_t LenWord = 3'd4;

    // one RAM cycle as asked for by a sequencer
    typedef struct packed {
        logic                  active;
        logic                  write;
        logic [`MB_ADDR_W-1:0] addr;
        logic [7:0]            wData;
    } busCmd_t;

    // current owner of the RAM
    typedef enum logic [1:0] {
        GrNone  = 2'd0,
        GrFetch = 2'd1,
        GrData  = 2'd2
    } grant_t;

endpackage

`default_nettype wire

/* hdl/fetchSequencer.sv */
`default_nettype none
`include "memBridge_params.svh"

module fetchSequencer import memBridgePkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   i_advance,
    input  wire                   i_grant,
    input  wire                   i_fetchEn,
    input  wire [`MB_ADDR_W-1:0]  i_fetchAddr,
    input  wire [7:0]             i_memRData,
    output busCmd_t               o_cmd,
    output logic                  o_fetchDone,
    output logic [`MB_WORD_W-1:0] o_fetchInst
);
    logic                  busy;
    logic [2:0]            stage;
    logic [`MB_ADDR_W-1:0] base;
    logic [`MB_WORD_W-1:0] collect;
    logic                  rdPend;
    logic [1:0]            slot;
    logic                  lastStage;

    // byte slot of the read issued one advancing cycle ago
    assign slot      = stage[1:0] - 2'd1;
    assign lastStage = (stage == 3'(`MB_FETCH_LEN));

    // stage 0 is issued straight from the request while still idle
    always_comb begin
        o_cmd.write = 1'b0;
        o_cmd.wData = 8'h00;
        if (busy) begin
            o_cmd.active = !lastStage;
            o_cmd.addr   = base + `MB_ADDR_W'(stage);
        end else begin
            o_cmd.active = i_fetchEn;
            o_cmd.addr   = i_fetchAddr;
        end
    end

    assign o_fetchDone = busy && lastStage && i_advance;

    // top byte is live unless a stall already parked it in collect
    assign o_fetchInst = rdPend ? {i_memRData, collect[23:0]} : collect;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            stage  <= 3'd0;
            rdPend <= 1'b0;
        end else begin
            rdPend <= i_advance && i_grant && o_cmd.active;
            if (i_advance) begin
                if (!busy) begin
                    if (i_grant) begin
                        busy  <= 1'b1;
                        stage <= 3'd1;
                    end
                end else if (lastStage) begin
                    busy  <= 1'b0;
                    stage <= 3'd0;
                end else begin
                    stage <= stage + 3'd1;
                end
            end
        end
    end

    // read data is caught even in a stalled cycle, the RAM moves on anyway
    always_ff @(posedge clk) begin
        if (i_advance && !busy && i_grant) begin
            base <= i_fetchAddr;
        end
        if (rdPend) begin
            collect[8*slot +: 8] <= i_memRData;
        end
    end

endmodule

`default_nettype wire

/* hdl/dataSequencer.sv */
`default_nettype none
`include "memBridge_params.svh"

module dataSequencer import memBridgePkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   i_advance,
    input  wire                   i_grant,
    input  wire                   i_dataEn,
    input  wire                   i_dataStore,
    input  wire accLen_t          i_dataLen,
    input  wire [`MB_ADDR_W-1:0]  i_dataAddr,
    input  wire [`MB_WORD_W-1:0]  i_dataWData,
    input  wire [7:0]             i_memRData,
    output busCmd_t               o_cmd,
    output logic                  o_dataDone,
    output logic [`MB_WORD_W-1:0] o_dataRData
);
    logic                  busy;
    logic [2:0]            stage;
    logic [`MB_ADDR_W-1:0] base;
    accLen_t               lenReg;
    logic                  storeReg;
    logic [`MB_WORD_W-1:0] wordReg;
    logic [`MB_WORD_W-1:0] collect;
    logic [`MB_WORD_W-1:0] loadWord;
    logic                  rdPend;
    logic [1:0]            slot;
    logic                  owned;
    logic                  curStore;
    accLen_t               curLen;

    // while idle the live request stands in for the latched one
    assign owned    = busy || i_grant;
    assign curStore = busy ? storeReg : i_dataStore;
    assign curLen   = busy ? lenReg : i_dataLen;
    assign slot     = stage[1:0] - 2'd1;

    always_comb begin
        o_cmd.write = curStore;
        if (busy) begin
            o_cmd.active = storeReg || (stage != lenReg);
            o_cmd.addr   = base + `MB_ADDR_W'(stage);
            o_cmd.wData  = wordReg[8*stage[1:0] +: 8];
        end else begin
            o_cmd.active = i_dataEn;
            o_cmd.addr   = i_dataAddr;
            o_cmd.wData  = i_dataWData[7:0];
        end
    end

    // store ends with its last write, load one cycle after its last address
    always_comb begin
        if (curStore) begin
            o_dataDone = i_advance && owned && (stage == curLen - 3'd1);
        end else begin
            o_dataDone = i_advance && busy && (stage == lenReg);
        end
    end

    always_comb begin
        loadWord = collect;
        if (rdPend) begin
            loadWord[8*slot +: 8] = i_memRData;
        end
        case (lenReg)
            LenByte: o_dataRData = {24'h0, loadWord[7:0]};
            LenHalf: o_dataRData = {16'h0, loadWord[15:0]};
            LenWord: o_dataRData = loadWord;
            default: o_dataRData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            stage  <= 3'd0;
            rdPend <= 1'b0;
        end else begin
            rdPend <= i_advance && owned && o_cmd.active && !o_cmd.write;
            if (i_advance && owned) begin
                if (o_dataDone) begin
                    busy  <= 1'b0;
                    stage <= 3'd0;
                end else begin
                    busy  <= 1'b1;
                    stage <= stage + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_advance && !busy && i_grant) begin
            base     <= i_dataAddr;
            lenReg   <= i_dataLen;
            storeReg <= i_dataStore;
            wordReg  <= i_dataWData;
        end
        if (rdPend) begin
            collect[8*slot +: 8] <= i_memRData;
        end
    end

endmodule

`default_nettype wire

/* hdl/busArbiter.sv */
`default_nettype none
`include "memBridge_params.svh"

module busArbiter import memBridgePkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   i_rdy,
    input  wire                   i_ioBufferFull,
    input  wire                   i_fetchEn,
    input  wire                   i_dataEn,
    input  wire busCmd_t          i_fetchCmd,
    input  wire busCmd_t          i_dataCmd,
    input  wire                   i_fetchDone,
    input  wire                   i_dataDone,
    output logic                  o_advance,
    output logic                  o_fetchGrant,
    output logic                  o_dataGrant,
    output logic                  o_fetchWait,
    output logic                  o_dataWait,
    output logic                  o_memWrite,
    output logic [`MB_ADDR_W-1:0] o_memAddr,
    output logic [7:0]            o_memWData
);
    grant_t  grReg;
    grant_t  owner;
    busCmd_t selCmd;
    logic    ownerDone;

    assign o_advance = i_rdy && !i_ioBufferFull;

    // a held grant wins, otherwise data before fetch
    always_comb begin
        if (grReg != GrNone) begin
            owner = grReg;
        end else if (o_advance && i_dataEn) begin
            owner = GrData;
        end else if (o_advance && i_fetchEn) begin
            owner = GrFetch;
        end else begin
            owner = GrNone;
        end
    end

    assign o_fetchGrant = (owner == GrFetch);
    assign o_dataGrant  = (owner == GrData);
    assign ownerDone    = (o_fetchGrant && i_fetchDone) || (o_dataGrant && i_dataDone);

    assign o_fetchWait = i_fetchEn && o_dataGrant;
    assign o_dataWait  = i_dataEn && o_fetchGrant;

    // a one-cycle store takes and drops the grant in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            grReg <= GrNone;
        end else if (o_advance) begin
            grReg <= ownerDone ? GrNone : owner;
        end
    end

    always_comb begin
        case (owner)
            GrFetch: selCmd = i_fetchCmd;
            GrData:  selCmd = i_dataCmd;
            default: selCmd = '0;
        endcase
    end

    // idle or stalled cycles become a read of address 0
    always_comb begin
        if (o_advance && selCmd.active) begin
            o_memWrite = selCmd.write;
            o_memAddr  = selCmd.addr;
            o_memWData = selCmd.wData;
        end else begin
            o_memWrite = 1'b0;
            o_memAddr  = '0;
            o_memWData = 8'h00;
        end
    end

endmodule

`default_nettype wire

/* hdl/memBridge.sv */
`default_nettype none
`include "memBridge_params.svh"

module memBridge import memBridgePkg::*; (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  i_rdy,
    input  wire                  i_ioBufferFull,
    input  wire                  i_fetchEn,
    input  wire [`MB_ADDR_W-1:0] i_fetchAddr,
    output wire                  o_fetchDone,
    output wire [`MB_WORD_W-1:0] o_fetchInst,
    input  wire                  i_dataEn,
    input  wire                  i_dataStore,
    input  wire accLen_t         i_dataLen,
    input  wire [`MB_ADDR_W-1:0] i_dataAddr,
    input  wire [`MB_WORD_W-1:0] i_dataWData,
    output wire                  o_dataDone,
    output wire [`MB_WORD_W-1:0] o_dataRData,
    output wire                  o_fetchWait,
    output wire                  o_dataWait,
    output wire                  o_memWrite,
    output wire [`MB_ADDR_W-1:0] o_memAddr,
    output wire [7:0]            o_memWData,
    input  wire [7:0]            i_memRData
);
    busCmd_t fetchCmd;
    busCmd_t dataCmd;
    wire     advance;
    wire     fetchGrant;
    wire     dataGrant;

    fetchSequencer u_fetchSeq (
        .clk         (clk),
        .rst         (rst),
        .i_advance   (advance),
        .i_grant     (fetchGrant),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .i_memRData  (i_memRData),
        .o_cmd       (fetchCmd),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst)
    );

    dataSequencer u_dataSeq (
        .clk         (clk),
        .rst         (rst),
        .i_advance   (advance),
        .i_grant     (dataGrant),
        .i_dataEn    (i_dataEn),
        .i_dataStore (i_dataStore),
        .i_dataLen   (i_dataLen),
        .i_dataAddr  (i_dataAddr),
        .i_dataWData (i_dataWData),
        .i_memRData  (i_memRData),
        .o_cmd       (dataCmd),
        .o_dataDone  (o_dataDone),
        .o_dataRData (o_dataRData)
    );

    busArbiter u_arbiter (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_fetchEn      (i_fetchEn),
        .i_dataEn       (i_dataEn),
        .i_fetchCmd     (fetchCmd),
        .i_dataCmd      (dataCmd),
        .i_fetchDone    (o_fetchDone),
        .i_dataDone     (o_dataDone),
        .o_advance      (advance),
        .o_fetchGrant   (fetchGrant),
        .o_dataGrant    (dataGrant),
        .o_fetchWait    (o_fetchWait),
        .o_dataWait     (o_dataWait),
        .o_memWrite     (o_memWrite),
        .o_memAddr      (o_memAddr),
        .o_memWData     (o_memWData)
    );

endmodule

`default_nettype wire

/* test/ramModel.sv */
`default_nettype none

module ramModel #(
    parameter int Depth = 1024
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         i_write,
    input  wire  [31:0] i_addr,
    input  wire  [7:0]  i_wData,
    output logic [7:0]  o_rData,
    output logic [31:0] o_writeCount
);
    timeunit 1ns;
    timeprecision 1ps;

    // preloaded by the testbench through the hierarchy
    logic [7:0] mem [0:Depth-1];

    // one-cycle read latency, old data on a write to the same address
    always @(posedge clk) begin
        o_rData <= mem[i_addr % Depth];
        if (i_write) begin
            mem[i_addr % Depth] <= i_wData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_writeCount <= '0;
        end else if (i_write) begin
            o_writeCount <= o_writeCount + 32'd1;
        end
    end

endmodule

`default_nettype wire

/* test/tbMemBridge.sv */
`default_nettype none
`include "memBridge_params.svh"

module tbMemBridge import memBridgePkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MaxCycles = 2000;
    localparam int DoneLimit = 32;

    logic                  clk;
    logic                  rst;
    logic                  rdy;
    logic                  ioFull;
    logic                  fetchEn;
    logic [`MB_ADDR_W-1:0] fetchAddr;
    logic                  dataEn;
    logic                  dataStore;
    accLen_t               dataLen;
    logic [`MB_ADDR_W-1:0] dataAddr;
    logic [`MB_WORD_W-1:0] dataWData;
    wire                   fetchDone;
    wire  [`MB_WORD_W-1:0] fetchInst;
    wire                   dataDone;
    wire  [`MB_WORD_W-1:0] dataRData;
    wire                   fetchWait;
    wire                   dataWait;
    wire                   memWrite;
    wire  [`MB_ADDR_W-1:0] memAddr;
    wire  [7:0]            memWData;
    wire  [7:0]            memRData;
    wire  [31:0]           writeCount;

    logic [7:0]  shadow [0:1023];
    logic [31:0] rnd;
    int          cycles;
    int          errors;
    int          testsOk;
    int          testsBad;

    memBridge u_dut (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (rdy),
        .i_ioBufferFull (ioFull),
        .i_fetchEn      (fetchEn),
        .i_fetchAddr    (fetchAddr),
        .o_fetchDone    (fetchDone),
        .o_fetchInst    (fetchInst),
        .i_dataEn       (dataEn),
        .i_dataStore    (dataStore),
        .i_dataLen      (dataLen),
        .i_dataAddr     (dataAddr),
        .i_dataWData    (dataWData),
        .o_dataDone     (dataDone),
        .o_dataRData    (dataRData),
        .o_fetchWait    (fetchWait),
        .o_dataWait     (dataWait),
        .o_memWrite     (memWrite),
        .o_memAddr      (memAddr),
        .o_memWData     (memWData),
        .i_memRData     (memRData)
    );

    ramModel u_ram (
        .clk          (clk),
        .rst          (rst),
        .i_write      (memWrite),
        .i_addr       (memAddr),
        .i_wData      (memWData),
        .o_rData      (memRData),
        .o_writeCount (writeCount)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MaxCycles) begin
            $display("timeout: run still busy after %0d cycles", MaxCycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // little-endian, zero-extended view of the shadow memory
    function automatic logic [31:0] shadowWord(input logic [31:0] addr, input int len);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < len; i++) begin
            w[8*i +: 8] = shadow[addr + i];
        end
        return w;
    endfunction

    // every stalled cycle up to the event pushes it out by one
    function automatic int stallShift(input int nominal, input logic [31:0] stallMask);
        int slot;
        slot = nominal;
        for (int i = 0; i <= slot && i < 32; i++) begin
            if (stallMask[i]) begin
                slot++;
            end
        end
        return slot;
    endfunction

    task automatic failValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("Fail %s: expected %h, got %h", name, exp, act);
        errors++;
    endtask

    task automatic finishTest(input string name, input int errBefore);
        if (errors == errBefore) begin
            testsOk++;
            $display("%s: ok", name);
        end else begin
            testsBad++;
            $display("%s: %0d errors", name, errors - errBefore);
        end
    endtask

    task automatic fillMemory();
        rnd = 32'h80bd;
        for (int i = 0; i < 1024; i++) begin
            rnd = xorshift(rnd);
            shadow[i] = rnd[7:0] ^ 8'(i) ^ 8'(i >> 8);
            u_ram.mem[i] = shadow[i];
        end
    endtask

    // one request held until done, stall levels per cycle from the masks
    task automatic doAccess(input bit fetch, input bit store, input accLen_t len,
                            input logic [31:0] addr, input logic [31:0] wData,
                            input logic [31:0] fullMask, input logic [31:0] rdyLowMask,
                            output logic [31:0] result, output int doneSlot);
        int   k;
        logic done;
        k = 0;
        done = 1'b0;
        doneSlot = -1;
        result = '0;
        while (!done && k < DoneLimit) begin
            @(negedge clk);
            ioFull = fullMask[k];
            rdy    = !rdyLowMask[k];
            if (fetch) begin
                fetchEn   = 1'b1;
                fetchAddr = addr;
            end else begin
                dataEn    = 1'b1;
                dataStore = store;
                dataLen   = len;
                dataAddr  = addr;
                dataWData = wData;
            end
            #5;
            if ((ioFull || !rdy) && (memWrite !== 1'b0 || memAddr !== '0)) begin
                $display("RAM not parked on a read of address 0 in stalled cycle %0d", k);
                errors++;
            end
            done = ((fetch ? fetchDone : dataDone) === 1'b1);
            if (done) begin
                result   = fetch ? fetchInst : dataRData;
                doneSlot = k;
            end
            k++;
        end
        @(negedge clk);
        fetchEn = 1'b0;
        dataEn  = 1'b0;
        ioFull  = 1'b0;
        rdy     = 1'b1;
        if (!done) begin
            $display("no done pulse within %0d cycles of the request", DoneLimit);
            errors++;
        end
    endtask

    task automatic readAndCheck(input bit fetch, input logic [31:0] addr, input accLen_t len,
                                input logic [31:0] fullMask, input logic [31:0] rdyLowMask);
        logic [31:0] res;
        int          slot;
        int          n;
        n = fetch ? `MB_FETCH_LEN : len;
        doAccess(fetch, 1'b0, len, addr, '0, fullMask, rdyLowMask, res, slot);
        if (slot != stallShift(n, fullMask | rdyLowMask)) begin
            failValue(fetch ? "o_fetchDone cycle" : "o_dataDone cycle",
                      stallShift(n, fullMask | rdyLowMask), slot);
        end
        if (res !== shadowWord(addr, n)) begin
            failValue(fetch ? "o_fetchInst" : "o_dataRData", shadowWord(addr, n), res);
        end
    endtask

    task automatic storeAndCheck(input logic [31:0] addr, input accLen_t len,
                                 input logic [31:0] wData, input logic [31:0] fullMask,
                                 input logic [31:0] rdyLowMask);
        logic [31:0] res;
        logic [31:0] idx;
        int          slot;
        int          wc0;
        int          n;
        n = len;
        wc0 = writeCount;
        doAccess(1'b0, 1'b1, len, addr, wData, fullMask, rdyLowMask, res, slot);
        if (slot != stallShift(n - 1, fullMask | rdyLowMask)) begin
            failValue("o_dataDone cycle", stallShift(n - 1, fullMask | rdyLowMask), slot);
        end
        if (writeCount - wc0 != n) begin
            failValue("write count", n, writeCount - wc0);
        end
        for (int i = 0; i < n; i++) begin
            shadow[addr + i] = wData[8*i +: 8];
        end
        // stored bytes plus one neighbor on each side
        for (int i = 0; i < n + 2; i++) begin
            idx = addr - 1 + i;
            if (u_ram.mem[idx] !== shadow[idx]) begin
                failValue("RAM byte", shadow[idx], u_ram.mem[idx]);
            end
        end
    endtask

    task automatic testReset();
        int errBefore;
        errBefore = errors;
        #5;
        if (fetchDone !== 1'b0) failValue("o_fetchDone", 0, fetchDone);
        if (dataDone !== 1'b0) failValue("o_dataDone", 0, dataDone);
        if (memWrite !== 1'b0) failValue("o_memWrite", 0, memWrite);
        if (fetchWait !== 1'b0) failValue("o_fetchWait", 0, fetchWait);
        if (dataWait !== 1'b0) failValue("o_dataWait", 0, dataWait);
        finishTest("reset", errBefore);
    endtask

    task automatic testFetch();
        int errBefore;
        errBefore = errors;
        readAndCheck(1'b1, 12, LenWord, 0, 0);
        readAndCheck(1'b1, 301, LenWord, 0, 0);
        finishTest("fetch", errBefore);
    endtask

    task automatic testLoads();
        int errBefore;
        errBefore = errors;
        readAndCheck(1'b0, 100, LenByte, 0, 0);
        readAndCheck(1'b0, 203, LenHalf, 0, 0);
        readAndCheck(1'b0, 517, LenWord, 0, 0);
        finishTest("loads", errBefore);
    endtask

    task automatic testStores();
        int errBefore;
        errBefore = errors;
        rnd = xorshift(rnd);
        storeAndCheck(410, LenByte, rnd, 0, 0);
        readAndCheck(1'b0, 410, LenByte, 0, 0);
        rnd = xorshift(rnd);
        storeAndCheck(421, LenHalf, rnd, 0, 0);
        readAndCheck(1'b0, 421, LenHalf, 0, 0);
        rnd = xorshift(rnd);
        storeAndCheck(433, LenWord, rnd, 0, 0);
        readAndCheck(1'b0, 433, LenWord, 0, 0);
        finishTest("stores", errBefore);
    endtask

    // load and fetch raised together, load goes first
    task automatic testContention();
        int          errBefore;
        int          k;
        int          dataSlot;
        int          fetchSlot;
        logic [31:0] loadRes;
        logic [31:0] instRes;
        errBefore = errors;
        k = 0;
        dataSlot = -1;
        fetchSlot = -1;
        while (fetchSlot < 0 && k < DoneLimit) begin
            @(negedge clk);
            if (k == 0) begin
                fetchEn   = 1'b1;
                fetchAddr = 600;
                dataEn    = 1'b1;
                dataStore = 1'b0;
                dataLen   = LenWord;
                dataAddr  = 700;
            end
            if (dataSlot >= 0) begin
                // load asked for again once the fetch owns the RAM
                dataEn = (k > dataSlot + 1);
            end
            #5;
            if (fetchWait !== (dataSlot < 0)) failValue("o_fetchWait", dataSlot < 0, fetchWait);
            if (dataWait !== (dataSlot >= 0 && k > dataSlot + 1)) begin
                failValue("o_dataWait", dataSlot >= 0 && k > dataSlot + 1, dataWait);
            end
            if (dataDone === 1'b1 && dataSlot < 0) begin
                dataSlot = k;
                loadRes  = dataRData;
            end
            if (fetchDone === 1'b1) begin
                fetchSlot = k;
                instRes   = fetchInst;
            end
            k++;
        end
        @(negedge clk);
        fetchEn = 1'b0;
        dataEn  = 1'b0;
        if (fetchSlot < 0) begin
            $display("fetch never finished behind the load");
            errors++;
        end
        if (dataSlot != 4) failValue("o_dataDone cycle", 4, dataSlot);
        if (fetchSlot != 9) failValue("o_fetchDone cycle", 9, fetchSlot);
        if (loadRes !== shadowWord(700, 4)) failValue("o_dataRData", shadowWord(700, 4), loadRes);
        if (instRes !== shadowWord(600, 4)) failValue("o_fetchInst", shadowWord(600, 4), instRes);
        finishTest("contention", errBefore);
    endtask

    task automatic testStalls();
        int errBefore;
        errBefore = errors;
        rnd = xorshift(rnd);
        storeAndCheck(800, LenWord, rnd, 32'h2, 32'h18);
        readAndCheck(1'b1, 800, LenWord, 32'h4, 32'h60);
        finishTest("stalls", errBefore);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        rdy       = 1'b1;
        ioFull    = 1'b0;
        fetchEn   = 1'b0;
        fetchAddr = '0;
        dataEn    = 1'b0;
        dataStore = 1'b0;
        dataLen   = LenByte;
        dataAddr  = '0;
        dataWData = '0;
        cycles    = 0;
        errors    = 0;
        testsOk   = 0;
        testsBad  = 0;
        fillMemory();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        testReset();
        testFetch();
        testLoads();
        testStores();
        testContention();
        testStalls();
        $display("summary: %0d tests ok, %0d tests with errors", testsOk, testsBad);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* memBridge.f */
+incdir+hdl
hdl/memBridgePkg.sv
hdl/fetchSequencer.sv
hdl/dataSequencer.sv
hdl/busArbiter.sv
hdl/memBridge.sv
test/ramModel.sv
test/tbMemBridge.sv

/* Bender.yml */
package:
  name: memBridge

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/memBridgePkg.sv
      - hdl/fetchSequencer.sv
      - hdl/dataSequencer.sv
      - hdl/busArbiter.sv
      - hdl/memBridge.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/ramModel.sv
      - test/tbMemBridge.sv
